// File: wb_pkg.sv
`default_nettype none

// wishbone classic slave widths
package wb_pkg;

  localparam int adr_w = 32; // byte address
  localparam int dat_w = 32;
  localparam int sel_w = dat_w / 8; // one lane per byte

endpackage

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // geometry
  localparam int ways  = 4;
  localparam int way_w = 2;
  localparam int sets  = 64;
  localparam int words = 4; // words per line

  // address fields, low to high
  localparam int byte_w  = 2;
  localparam int word_w  = 2;
  localparam int index_w = 6;
  localparam int tag_w   = 22; // adr[31:10]

  localparam int age_w = 2; // true lru age per way

  // controller states
  localparam int st_w = 2;
  localparam logic [st_w-1:0] st_init   = 2'd0;
  localparam logic [st_w-1:0] st_idle   = 2'd1;
  localparam logic [st_w-1:0] st_lookup = 2'd2;
  localparam logic [st_w-1:0] st_resp   = 2'd3;

endpackage

`default_nettype wire

// File: dcache_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_ram (
  input  wire                                                   clk,
  input  wire  [dcache_pkg::index_w-1:0]                        rd_index,
  input  wire  [dcache_pkg::word_w-1:0]                         rd_word,
  output logic [wb_pkg::dat_w-1:0]                              rdata,
  input  wire                                                   we,
  input  wire  [dcache_pkg::index_w-1:0]                        wr_index,
  input  wire  [dcache_pkg::word_w-1:0]                         wr_word,
  input  wire  [wb_pkg::sel_w-1:0]                              wr_sel,
  input  wire  [wb_pkg::dat_w-1:0]                              wr_data
);

  logic [wb_pkg::dat_w-1:0] mem [dcache_pkg::sets * dcache_pkg::words];
  logic [dcache_pkg::index_w+dcache_pkg::word_w-1:0] rd_addr_q;
  logic [dcache_pkg::index_w+dcache_pkg::word_w-1:0] wr_addr;

  assign wr_addr = {wr_index, wr_word};

  // read through the registered address, so a write in the
  // address cycle shows up on rdata (write first)
  assign rdata = mem[rd_addr_q];

  always_ff @(posedge clk) begin
    rd_addr_q <= {rd_index, rd_word};
    for (int b = 0; b < wb_pkg::sel_w; b++) begin
      if (we && wr_sel[b]) begin
        mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8]; // byte lane merge
      end
    end
  end

endmodule

`default_nettype wire

// File: dcache_tag_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_ram (
  input  wire                            clk,
  input  wire  [dcache_pkg::index_w-1:0] rd_index,
  output logic [dcache_pkg::tag_w-1:0]   tag,
  output logic                           valid,
  input  wire                            we,
  input  wire  [dcache_pkg::index_w-1:0] wr_index,
  input  wire  [dcache_pkg::tag_w-1:0]   wr_tag,
  input  wire                            wr_valid
);

  // entry is {valid, tag}
  logic [dcache_pkg::tag_w:0] mem [dcache_pkg::sets];
  logic [dcache_pkg::index_w-1:0] rd_index_q;
  logic [dcache_pkg::tag_w:0] entry;

  assign entry = mem[rd_index_q];
  assign valid = entry[dcache_pkg::tag_w];
  assign tag   = entry[dcache_pkg::tag_w-1:0];

  always_ff @(posedge clk) begin
    rd_index_q <= rd_index;
    if (we) begin
      mem[wr_index] <= {wr_valid, wr_tag}; // init sweep writes valid low
    end
  end

endmodule

`default_nettype wire

// File: dcache_way.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_way (
  input  wire                            clk,
  input  wire  [dcache_pkg::index_w-1:0] rd_index,
  input  wire  [dcache_pkg::word_w-1:0]  rd_word,
  input  wire  [dcache_pkg::tag_w-1:0]   cmp_tag,
  output logic                           hit,
  output logic [wb_pkg::dat_w-1:0]       rdata,
  input  wire                            data_we,
  input  wire                            tag_we,
  input  wire  [dcache_pkg::index_w-1:0] wr_index,
  input  wire  [dcache_pkg::word_w-1:0]  wr_word,
  input  wire  [wb_pkg::sel_w-1:0]       wr_sel,
  input  wire  [wb_pkg::dat_w-1:0]       wr_data,
  input  wire  [dcache_pkg::tag_w-1:0]   wr_tag,
  input  wire                            wr_valid
);

  logic [dcache_pkg::tag_w-1:0] cmp_tag_q;
  logic [dcache_pkg::tag_w-1:0] stored_tag;
  logic                         stored_valid;

  always_ff @(posedge clk) begin
    cmp_tag_q <= cmp_tag; // lines up with the tag ram read
  end

  assign hit = stored_valid && (stored_tag == cmp_tag_q);

  dcache_data_ram u_data_ram (
    .clk      (clk),
    .rd_index (rd_index),
    .rd_word  (rd_word),
    .rdata    (rdata),
    .we       (data_we),
    .wr_index (wr_index),
    .wr_word  (wr_word),
    .wr_sel   (wr_sel),
    .wr_data  (wr_data)
  );

  dcache_tag_ram u_tag_ram (
    .clk      (clk),
    .rd_index (rd_index),
    .tag      (stored_tag),
    .valid    (stored_valid),
    .we       (tag_we),
    .wr_index (wr_index),
    .wr_tag   (wr_tag),
    .wr_valid (wr_valid)
  );

endmodule

`default_nettype wire

// File: dcache_lru.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_lru (
  input  wire                            clk,
  input  wire  [dcache_pkg::index_w-1:0] rd_index,
  output logic [dcache_pkg::way_w-1:0]   victim,
  input  wire                            upd_en,
  input  wire  [dcache_pkg::index_w-1:0] upd_index,
  input  wire  [dcache_pkg::way_w-1:0]   upd_way,
  input  wire                            init_en,
  input  wire  [dcache_pkg::index_w-1:0] init_index
);

  logic [dcache_pkg::ways*dcache_pkg::age_w-1:0] mem [dcache_pkg::sets];
  logic [dcache_pkg::index_w-1:0] rd_index_q;
  logic [dcache_pkg::ways*dcache_pkg::age_w-1:0] ages;
  logic [dcache_pkg::ways*dcache_pkg::age_w-1:0] new_ages;
  logic [dcache_pkg::ways*dcache_pkg::age_w-1:0] seed_ages;
  logic [dcache_pkg::age_w-1:0] acc_age;

  assign ages    = mem[rd_index_q];
  assign acc_age = ages[upd_way*dcache_pkg::age_w +: dcache_pkg::age_w];

  // oldest way has the top age
  always_comb begin
    victim = '0;
    for (int w = 0; w < dcache_pkg::ways; w++) begin
      if (ages[w*dcache_pkg::age_w +: dcache_pkg::age_w] ==
          dcache_pkg::age_w'(dcache_pkg::ways - 1)) begin
        victim = dcache_pkg::way_w'(w);
      end
    end
  end

  // update is computed on the ages read out for this set,
  // upd_index is always the index read the cycle before
  always_comb begin
    for (int w = 0; w < dcache_pkg::ways; w++) begin
      seed_ages[w*dcache_pkg::age_w +: dcache_pkg::age_w] = dcache_pkg::age_w'(w);
      if (dcache_pkg::way_w'(w) == upd_way) begin
        new_ages[w*dcache_pkg::age_w +: dcache_pkg::age_w] = '0;
      end else if (ages[w*dcache_pkg::age_w +: dcache_pkg::age_w] < acc_age) begin
        new_ages[w*dcache_pkg::age_w +: dcache_pkg::age_w] =
          ages[w*dcache_pkg::age_w +: dcache_pkg::age_w] + 1'b1; // younger ones age
      end else begin
        new_ages[w*dcache_pkg::age_w +: dcache_pkg::age_w] =
          ages[w*dcache_pkg::age_w +: dcache_pkg::age_w];
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_index_q <= rd_index;
    if (init_en) begin
      mem[init_index] <= seed_ages;
    end else if (upd_en) begin
      mem[upd_index] <= new_ages;
    end
  end

endmodule

`default_nettype wire

// File: dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
  input  wire                                           clk,
  input  wire                                           rst,
  input  wire                                           wb_cyc,
  input  wire                                           wb_stb,
  input  wire                                           wb_we,
  input  wire  [wb_pkg::adr_w-1:0]                      wb_adr,
  input  wire  [wb_pkg::dat_w-1:0]                      wb_dat_w,
  input  wire  [wb_pkg::sel_w-1:0]                      wb_sel,
  output logic [wb_pkg::dat_w-1:0]                      wb_dat_r,
  output logic                                          wb_ack,
  output logic                                          wb_err,
  input  wire  [dcache_pkg::ways-1:0]                   way_hit,
  input  wire  [dcache_pkg::ways*wb_pkg::dat_w-1:0]     way_rdata,
  output logic [dcache_pkg::index_w-1:0]                rd_index,
  output logic [dcache_pkg::word_w-1:0]                 rd_word,
  output logic [dcache_pkg::tag_w-1:0]                  cmp_tag,
  output logic [dcache_pkg::ways-1:0]                   data_we,
  output logic [dcache_pkg::ways-1:0]                   tag_we,
  output logic [dcache_pkg::index_w-1:0]                wr_index,
  output logic [dcache_pkg::word_w-1:0]                 wr_word,
  output logic [wb_pkg::sel_w-1:0]                      wr_sel,
  output logic [wb_pkg::dat_w-1:0]                      wr_data,
  output logic [dcache_pkg::tag_w-1:0]                  wr_tag,
  output logic                                          wr_valid,
  input  wire  [dcache_pkg::way_w-1:0]                  victim,
  output logic                                          upd_en,
  output logic [dcache_pkg::way_w-1:0]                  upd_way,
  output logic                                          init_en,
  output logic [dcache_pkg::index_w-1:0]                init_index
);

  logic [dcache_pkg::st_w-1:0]    state;
  logic [dcache_pkg::index_w-1:0] init_cnt;
  logic                           req_we;
  logic [dcache_pkg::index_w-1:0] req_index;
  logic [dcache_pkg::word_w-1:0]  req_word;
  logic [dcache_pkg::tag_w-1:0]   req_tag;
  logic [wb_pkg::sel_w-1:0]       req_sel;
  logic [wb_pkg::dat_w-1:0]       req_dat;
  logic                           idle;
  logic                           lookup;
  logic                           hit_any;
  logic [dcache_pkg::way_w-1:0]   hit_way;
  logic [dcache_pkg::way_w-1:0]   sel_way;

  assign idle    = (state == dcache_pkg::st_idle);
  assign lookup  = (state == dcache_pkg::st_lookup);
  assign init_en = (state == dcache_pkg::st_init);

  // index and tag go to the rams straight from the bus in idle
  assign rd_index = idle ? wb_adr[dcache_pkg::byte_w+dcache_pkg::word_w +: dcache_pkg::index_w]
                         : req_index;
  assign rd_word  = idle ? wb_adr[dcache_pkg::byte_w +: dcache_pkg::word_w] : req_word;
  assign cmp_tag  = idle ? wb_adr[wb_pkg::adr_w-1 -: dcache_pkg::tag_w] : req_tag;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < dcache_pkg::ways; w++) begin
      if (way_hit[w]) hit_way = dcache_pkg::way_w'(w);
    end
  end

  assign hit_any = |way_hit;
  assign sel_way = hit_any ? hit_way : victim; // allocate lru way on a miss

  always_comb begin
    for (int w = 0; w < dcache_pkg::ways; w++) begin
      data_we[w] = lookup && req_we && (sel_way == dcache_pkg::way_w'(w));
      tag_we[w]  = init_en ||
                   (lookup && req_we && !hit_any && (victim == dcache_pkg::way_w'(w)));
    end
  end

  assign wr_index   = init_en ? init_cnt : req_index;
  assign wr_word    = req_word;
  assign wr_sel     = req_sel;
  assign wr_data    = req_dat;
  assign wr_tag     = req_tag;
  assign wr_valid   = !init_en;
  assign init_index = init_cnt;
  assign upd_en     = lookup && (hit_any || req_we); // read miss leaves ages alone
  assign upd_way    = sel_way;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= dcache_pkg::st_init;
      init_cnt <= '0;
      wb_ack   <= 1'b0;
      wb_err   <= 1'b0;
    end else begin
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
      case (state)
        dcache_pkg::st_init: begin
          init_cnt <= init_cnt + 1'b1;
          if (init_cnt == dcache_pkg::index_w'(dcache_pkg::sets - 1)) begin
            state <= dcache_pkg::st_idle;
          end
        end
        dcache_pkg::st_idle: begin
          if (wb_cyc && wb_stb) state <= dcache_pkg::st_lookup;
        end
        dcache_pkg::st_lookup: begin
          wb_ack <= req_we || hit_any;
          wb_err <= !req_we && !hit_any;
          state  <= dcache_pkg::st_resp;
        end
        default: begin
          if (!wb_ack && !wb_err) state <= dcache_pkg::st_idle; // one quiet cycle
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (idle) begin
      req_we    <= wb_we;
      req_index <= rd_index;
      req_word  <= rd_word;
      req_tag   <= cmp_tag;
      req_sel   <= wb_sel;
      req_dat   <= wb_dat_w;
    end
    if (lookup) begin
      wb_dat_r <= way_rdata[hit_way*wb_pkg::dat_w +: wb_pkg::dat_w];
    end
  end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       wb_cyc,
  input  wire                       wb_stb,
  input  wire                       wb_we,
  input  wire  [wb_pkg::adr_w-1:0]  wb_adr,
  input  wire  [wb_pkg::dat_w-1:0]  wb_dat_w,
  input  wire  [wb_pkg::sel_w-1:0]  wb_sel,
  output wire  [wb_pkg::dat_w-1:0]  wb_dat_r,
  output wire                       wb_ack,
  output wire                       wb_err
);

  wire [dcache_pkg::ways-1:0]               way_hit;
  wire [dcache_pkg::ways*wb_pkg::dat_w-1:0] way_rdata;
  wire [dcache_pkg::index_w-1:0]            rd_index;
  wire [dcache_pkg::word_w-1:0]             rd_word;
  wire [dcache_pkg::tag_w-1:0]              cmp_tag;
  wire [dcache_pkg::ways-1:0]               data_we;
  wire [dcache_pkg::ways-1:0]               tag_we;
  wire [dcache_pkg::index_w-1:0]            wr_index;
  wire [dcache_pkg::word_w-1:0]             wr_word;
  wire [wb_pkg::sel_w-1:0]                  wr_sel;
  wire [wb_pkg::dat_w-1:0]                  wr_data;
  wire [dcache_pkg::tag_w-1:0]              wr_tag;
  wire                                      wr_valid;
  wire [dcache_pkg::way_w-1:0]              victim;
  wire                                      upd_en;
  wire [dcache_pkg::way_w-1:0]              upd_way;
  wire                                      init_en;
  wire [dcache_pkg::index_w-1:0]            init_index;

  dcache_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_sel     (wb_sel),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err),
    .way_hit    (way_hit),
    .way_rdata  (way_rdata),
    .rd_index   (rd_index),
    .rd_word    (rd_word),
    .cmp_tag    (cmp_tag),
    .data_we    (data_we),
    .tag_we     (tag_we),
    .wr_index   (wr_index),
    .wr_word    (wr_word),
    .wr_sel     (wr_sel),
    .wr_data    (wr_data),
    .wr_tag     (wr_tag),
    .wr_valid   (wr_valid),
    .victim     (victim),
    .upd_en     (upd_en),
    .upd_way    (upd_way),
    .init_en    (init_en),
    .init_index (init_index)
  );

  for (genvar w = 0; w < dcache_pkg::ways; w++) begin : g_way
    dcache_way u_way (
      .clk      (clk),
      .rd_index (rd_index),
      .rd_word  (rd_word),
      .cmp_tag  (cmp_tag),
      .hit      (way_hit[w]),
      .rdata    (way_rdata[w*wb_pkg::dat_w +: wb_pkg::dat_w]),
      .data_we  (data_we[w]),
      .tag_we   (tag_we[w]),
      .wr_index (wr_index),
      .wr_word  (wr_word),
      .wr_sel   (wr_sel),
      .wr_data  (wr_data),
      .wr_tag   (wr_tag),
      .wr_valid (wr_valid)
    );
  end

  dcache_lru u_lru (
    .clk        (clk),
    .rd_index   (rd_index),
    .victim     (victim),
    .upd_en     (upd_en),
    .upd_index  (wr_index), // same set as the lookup
    .upd_way    (upd_way),
    .init_en    (init_en),
    .init_index (init_index)
  );

endmodule

`default_nettype wire

// File: tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

  localparam int n_rand     = 200;
  localparam int n_xfer     = 4 + 2 + 4 + 10 + 8 + n_rand;
  localparam int wd_cycles  = n_xfer * 4 + 64 + 100;
  localparam int resp_limit = 200; // cycles to wait for ack or err
  localparam int idx_lo     = dcache_pkg::byte_w + dcache_pkg::word_w;
  localparam int tag_lo     = idx_lo + dcache_pkg::index_w;
  localparam int wa_w       = wb_pkg::adr_w - dcache_pkg::byte_w;

  logic                     clk;
  logic                     rst;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [wb_pkg::adr_w-1:0] wb_adr;
  logic [wb_pkg::dat_w-1:0] wb_dat_w;
  logic [wb_pkg::sel_w-1:0] wb_sel;
  wire  [wb_pkg::dat_w-1:0] wb_dat_r;
  wire                      wb_ack;
  wire                      wb_err;

  int          checks = 0;
  int          errors = 0;
  logic [31:0] lcg_state = 32'h2728;

  // reference model, per set and way, words kept by word address
  logic                          m_valid [dcache_pkg::sets][dcache_pkg::ways];
  logic [dcache_pkg::tag_w-1:0]  m_tag   [dcache_pkg::sets][dcache_pkg::ways];
  int                            m_age   [dcache_pkg::sets][dcache_pkg::ways];
  logic [wb_pkg::dat_w-1:0]      m_dat   [logic [wa_w-1:0]];
  logic [wb_pkg::sel_w-1:0]      m_known [logic [wa_w-1:0]]; // lanes with a defined value

  dcache_top u_dcache_top (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wb_err   (wb_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles", wd_cycles);
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] line_adr(input logic [dcache_pkg::tag_w-1:0] tag,
                                           input logic [dcache_pkg::index_w-1:0] idx,
                                           input logic [dcache_pkg::word_w-1:0] word);
    return {tag, idx, word, 2'b00};
  endfunction

  function automatic int index_of(input logic [31:0] adr);
    return int'(adr[idx_lo +: dcache_pkg::index_w]);
  endfunction

  function automatic int find_way(input logic [31:0] adr);
    int idx;
    int way;
    idx = index_of(adr);
    way = -1;
    for (int w = 0; w < dcache_pkg::ways; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == adr[tag_lo +: dcache_pkg::tag_w]) way = w;
    end
    return way;
  endfunction

  // accessed way goes to age 0, the younger ones age by one
  function automatic void touch(input int idx, input int way);
    int acc;
    acc = m_age[idx][way];
    for (int w = 0; w < dcache_pkg::ways; w++) begin
      if (m_age[idx][w] < acc) m_age[idx][w] = m_age[idx][w] + 1;
    end
    m_age[idx][way] = 0;
  endfunction

  function automatic void model_write(input logic [31:0] adr, input logic [31:0] dat,
                                      input logic [3:0] sel);
    int               idx;
    int               way;
    logic [wa_w-1:0]  wa;
    logic [wa_w-1:0]  key;
    logic [31:0]      d;
    logic [3:0]       k;
    idx = index_of(adr);
    wa  = adr[wb_pkg::adr_w-1:dcache_pkg::byte_w];
    way = find_way(adr);
    if (way < 0) begin
      for (int w = 0; w < dcache_pkg::ways; w++) begin
        if (m_age[idx][w] == dcache_pkg::ways - 1) way = w; // oldest way
      end
      if (m_valid[idx][way]) begin
        for (int n = 0; n < dcache_pkg::words; n++) begin
          key = {m_tag[idx][way], dcache_pkg::index_w'(idx), dcache_pkg::word_w'(n)};
          m_dat.delete(key);
          m_known.delete(key);
        end
      end
      m_valid[idx][way] = 1'b1;
      m_tag[idx][way]   = adr[tag_lo +: dcache_pkg::tag_w];
    end
    d = m_dat.exists(wa) ? m_dat[wa] : '0;
    k = m_known.exists(wa) ? m_known[wa] : '0;
    for (int b = 0; b < wb_pkg::sel_w; b++) begin
      if (sel[b]) begin
        d[8*b +: 8] = dat[8*b +: 8];
        k[b]        = 1'b1;
      end
    end
    m_dat[wa]   = d;
    m_known[wa] = k;
    touch(idx, way);
  endfunction

  function automatic void model_read(input logic [31:0] adr, output logic hit,
                                     output logic [31:0] dat, output logic [3:0] known);
    int              way;
    logic [wa_w-1:0] wa;
    wa    = adr[wb_pkg::adr_w-1:dcache_pkg::byte_w];
    way   = find_way(adr);
    hit   = (way >= 0);
    dat   = '0;
    known = '0;
    if (hit) begin
      touch(index_of(adr), way); // read miss leaves the ages alone
      if (m_known.exists(wa)) begin
        dat   = m_dat[wa];
        known = m_known[wa];
      end
    end
  endfunction

  // one wishbone classic transfer, held until ack or err
  task automatic xfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                      input logic [3:0] sel, output logic ack, output logic err,
                      output logic [31:0] rdat);
    int n;
    n = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    wb_sel   <= sel;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && !wb_err && n < resp_limit);
    ack  = wb_ack;
    err  = wb_err;
    rdat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic do_write(input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel);
    logic        ack;
    logic        err;
    logic [31:0] rd;
    xfer(1'b1, adr, dat, sel, ack, err, rd);
    model_write(adr, dat, sel);
    checks++;
    if (!ack || err) begin
      $display("write to %h got ack %0b and err %0b instead of a single ack", adr, ack, err);
      errors++;
    end
  endtask

  task automatic do_read(input logic [31:0] adr, output logic hit, output logic [31:0] rd);
    logic        ack;
    logic        err;
    logic        exp_hit;
    logic [31:0] exp;
    logic [31:0] m;
    logic [3:0]  known;
    xfer(1'b0, adr, '0, '0, ack, err, rd);
    model_read(adr, exp_hit, exp, known);
    hit = ack;
    for (int b = 0; b < wb_pkg::sel_w; b++) m[8*b +: 8] = {8{known[b]}};
    checks++;
    if (ack == err) begin
      $display("read of %h got ack %0b and err %0b", adr, ack, err);
      errors++;
    end else if (ack != exp_hit) begin
      $display("read of %h was a %s, the model says %s", adr,
               ack ? "hit" : "miss", exp_hit ? "hit" : "miss");
      errors++;
    end else if (ack && (rd & m) !== (exp & m)) begin
      $display("FAIL wb_dat_r at %h: expected %h, got %h (lanes %b)", adr, exp, rd, known);
      errors++;
    end
  endtask

  task automatic read_expect(input logic [31:0] adr, input logic want_hit);
    logic        hit;
    logic [31:0] rd;
    do_read(adr, hit, rd);
    checks++;
    if (hit !== want_hit) begin
      $display("read of %h should have %s", adr, want_hit ? "hit" : "missed");
      errors++;
    end
  endtask

  task automatic check_word(input logic [31:0] adr, input logic [31:0] want);
    logic        hit;
    logic [31:0] rd;
    do_read(adr, hit, rd);
    checks++;
    if (rd !== want) begin
      $display("FAIL wb_dat_r at %h: expected %h, got %h", adr, want, rd);
      errors++;
    end
  endtask

  task automatic test_done(input string name, input int e0);
    $display("%-12s finished with %0d errors", name, errors - e0);
  endtask

  task automatic test_init_misses();
    int e0;
    e0 = errors;
    read_expect(line_adr(22'h1, 6'd0, 2'd0), 1'b0);
    read_expect(line_adr(22'h2a5, 6'd5, 2'd2), 1'b0);
    read_expect(line_adr(22'h3fffff, 6'd63, 2'd3), 1'b0);
    read_expect(line_adr(22'h0, 6'd1, 2'd1), 1'b0);
    test_done("init", e0);
  endtask

  task automatic test_write_read();
    int e0;
    e0 = errors;
    do_write(line_adr(22'h5, 6'd8, 2'd1), 32'hcafe0001, 4'hf);
    check_word(line_adr(22'h5, 6'd8, 2'd1), 32'hcafe0001);
    test_done("write_read", e0);
  endtask

  task automatic test_byte_lanes();
    int e0;
    e0 = errors;
    do_write(line_adr(22'h7, 6'd9, 2'd2), 32'h11223344, 4'hf);
    do_write(line_adr(22'h7, 6'd9, 2'd2), 32'h000000aa, 4'b0001);
    do_write(line_adr(22'h7, 6'd9, 2'd2), 32'h00cc0000, 4'b0100);
    check_word(line_adr(22'h7, 6'd9, 2'd2), 32'h11cc33aa);
    test_done("byte_lanes", e0);
  endtask

  // five tags into one fresh set, A drops out
  task automatic test_eviction();
    int e0;
    e0 = errors;
    for (int t = 0; t < 5; t++) do_write(line_adr(22'h100 + 22'(t), 6'd16, 2'd0), 32'h0a0 + t, 4'hf);
    read_expect(line_adr(22'h100, 6'd16, 2'd0), 1'b0);
    for (int t = 1; t < 5; t++) read_expect(line_adr(22'h100 + 22'(t), 6'd16, 2'd0), 1'b1);
    test_done("eviction", e0);
  endtask

  task automatic test_lru_order();
    int e0;
    e0 = errors;
    for (int t = 0; t < 4; t++) do_write(line_adr(22'h200 + 22'(t), 6'd24, 2'd1), 32'hb00 + t, 4'hf);
    read_expect(line_adr(22'h200, 6'd24, 2'd1), 1'b1); // A becomes youngest
    do_write(line_adr(22'h204, 6'd24, 2'd1), 32'hb04, 4'hf);
    read_expect(line_adr(22'h201, 6'd24, 2'd1), 1'b0);
    read_expect(line_adr(22'h200, 6'd24, 2'd1), 1'b1);
    test_done("lru_order", e0);
  endtask

  // sets 32 to 39, four tags each, so nothing is evicted
  task automatic test_random();
    logic [31:0] r;
    logic [31:0] adr;
    logic [31:0] rd;
    logic [3:0]  sel;
    logic        hit;
    int          e0;
    e0 = errors;
    for (int i = 0; i < n_rand; i++) begin
      r   = next_rand();
      adr = line_adr(22'h300 + 22'(r[17:16]), 6'd32 + 6'(r[20:18]), r[22:21]);
      if (r[23]) begin
        sel = (find_way(adr) < 0) ? 4'hf : r[27:24]; // full lanes on allocation
        do_write(adr, next_rand(), sel);
      end else begin
        do_read(adr, hit, rd);
      end
    end
    test_done("random", e0);
  endtask

  initial begin
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
    for (int s = 0; s < dcache_pkg::sets; s++) begin
      for (int w = 0; w < dcache_pkg::ways; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_age[s][w]   = w; // init sweep seeds way numbers
      end
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_init_misses();
    test_write_read();
    test_byte_lanes();
    test_eviction();
    test_lru_order();
    test_random();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
wb_pkg.sv
dcache_pkg.sv
dcache_data_ram.sv
dcache_tag_ram.sv
dcache_way.sv
dcache_lru.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_dcache \
  -f vlog.f -o tb_dcache && ./obj_dir/tb_dcache > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
